// ==== hw/cache_axi_pkg.sv ====
`default_nettype none

package cache_axi_pkg;

	localparam int DATA_W = 32;
	localparam int ADDR_W = 32;
	localparam int STRB_W = DATA_W / 8;

	typedef enum logic [1:0] {
		AXI_BURST_FIXED = 2'b00,
		AXI_BURST_INCR  = 2'b01,
		AXI_BURST_WRAP  = 2'b10
	} axi_burst_e;

	// one-hot
	typedef enum logic [3:0] {
		ST_IDLE = 4'b0001,
		ST_ADDR = 4'b0010,
		ST_DATA = 4'b0100,
		ST_RESP = 4'b1000
	} bridge_state_e;

	typedef struct packed {
		logic              valid; // held until resp ready
		logic              write;
		logic              burst;
		logic              cached;
		logic [ADDR_W-1:0] addr;
		logic              data_ok; // write beat presented
		logic [STRB_W-1:0] strobe;
		logic [DATA_W-1:0] wdata;
	} cache_req_t;

	typedef struct packed {
		logic              ready; // grant pulse
		logic              data_ok;
		logic              data_last;
		logic [DATA_W-1:0] rdata;
	} cache_resp_t;

	// latched request, no data fields
	typedef struct packed {
		logic              write;
		logic              burst;
		logic              cached;
		logic [ADDR_W-1:0] addr;
	} sel_req_t;

	typedef struct packed {
		logic              valid;
		logic [ADDR_W-1:0] addr;
		logic [7:0]        len;
		logic [2:0]        size;
		axi_burst_e        burst;
		logic [3:0]        cache;
		logic [2:0]        prot;
	} axi_addr_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
		logic [STRB_W-1:0] strb;
		logic              last;
	} axi_w_t;

	typedef struct packed {
		logic              valid;
		logic [DATA_W-1:0] data;
		logic [1:0]        resp;
		logic              last;
	} axi_r_t;

	typedef struct packed {
		logic       valid;
		logic [1:0] resp;
	} axi_b_t;

endpackage

`default_nettype wire

// ==== hw/rr_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module rr_arbiter #(
	parameter int PORT_NUM = 2
) (
	input  logic                clk,
	input  logic                rst_n,
	input  logic [PORT_NUM-1:0] req_i,
	input  logic                take_i,
	output logic [PORT_NUM-1:0] grant_o
);

	localparam int PTR_W = (PORT_NUM > 1) ? $clog2(PORT_NUM) : 1;

	logic [PTR_W-1:0] ptr_q;
	logic [PTR_W-1:0] ptr_d;

	// cyclic search starting at the pointer
	always_comb begin
		int   idx;
		logic found;
		grant_o = '0;
		ptr_d   = ptr_q;
		found   = 1'b0;
		for (int off = 0; off < PORT_NUM; off++) begin
			idx = int'(ptr_q) + off;
			if (idx >= PORT_NUM)
				idx = idx - PORT_NUM;
			if (!found && req_i[idx]) begin
				found        = 1'b1;
				grant_o[idx] = 1'b1;
				ptr_d        = (idx == PORT_NUM - 1) ? '0 : PTR_W'(idx + 1); // winner + 1
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			ptr_q <= '0;
		end else if (take_i && |grant_o) begin
			ptr_q <= ptr_d;
		end
	end

endmodule

`default_nettype wire

// ==== hw/beat_counter.sv ====
`timescale 1ns/1ps
`default_nettype none

module beat_counter #(
	parameter int BURST_LEN = 4
) (
	input  logic clk,
	input  logic rst_n,
	input  logic start_i,
	input  logic burst_i,
	input  logic beat_i,
	output logic last_o
);

	localparam int CNT_W = (BURST_LEN > 1) ? $clog2(BURST_LEN) : 1;

	logic [CNT_W-1:0] cnt_q; // beats still to go after the current one

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			cnt_q <= '0;
		end else if (start_i) begin
			cnt_q <= burst_i ? CNT_W'(BURST_LEN - 1) : '0;
		end else if (beat_i && cnt_q != '0) begin
			cnt_q <= cnt_q - 1'b1;
		end
	end

	assign last_o = (cnt_q == '0);

endmodule

`default_nettype wire

// ==== hw/bridge_fsm.sv ====
`timescale 1ns/1ps
`default_nettype none

module bridge_fsm (
	input  logic                         clk,
	input  logic                         rst_n,
	input  logic                         grant_any_i,
	input  logic                         write_i,
	input  logic                         ar_ready_i,
	input  logic                         aw_ready_i,
	input  cache_axi_pkg::axi_r_t        r_i,
	input  logic                         w_fire_i,
	input  logic                         last_beat_i,
	input  logic                         b_valid_i,
	output cache_axi_pkg::bridge_state_e state_o,
	output logic                         take_o,
	output logic                         start_o
);

	import cache_axi_pkg::*;

	bridge_state_e state_q;
	bridge_state_e state_d;

	always_comb begin
		state_d = state_q;
		case (state_q)
			ST_IDLE: begin
				if (grant_any_i)
					state_d = ST_ADDR;
			end
			ST_ADDR: begin
				// valid is already high here, ready completes it
				if (write_i ? aw_ready_i : ar_ready_i)
					state_d = ST_DATA;
			end
			ST_DATA: begin
				if (!write_i && r_i.valid && r_i.last) begin
					state_d = ST_IDLE; // r_ready always high
				end else if (write_i && w_fire_i && last_beat_i) begin
					state_d = ST_RESP;
				end
			end
			ST_RESP: begin
				if (b_valid_i)
					state_d = ST_IDLE;
			end
			default: begin
				state_d = ST_IDLE;
			end
		endcase
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			state_q <= ST_IDLE;
		end else begin
			state_q <= state_d;
		end
	end

	assign state_o = state_q;
	assign take_o  = (state_q == ST_IDLE);
	assign start_o = (state_q == ST_IDLE) && grant_any_i; // loads beat counter

endmodule

`default_nettype wire

// ==== hw/req_capture.sv ====
`timescale 1ns/1ps
`default_nettype none

module req_capture #(
	parameter int PORT_NUM = 2
) (
	input  logic                                     clk,
	input  logic                                     rst_n,
	input  cache_axi_pkg::cache_req_t [PORT_NUM-1:0] req_i,
	input  logic [PORT_NUM-1:0]                      grant_i,
	input  logic                                     take_i,
	input  cache_axi_pkg::bridge_state_e             state_i,
	input  logic                                     w_ready_i,
	input  logic                                     last_i,
	output cache_axi_pkg::sel_req_t                  sel_o,
	output logic [PORT_NUM-1:0]                      sel_port_o,
	output cache_axi_pkg::axi_w_t                    w_o,
	output logic                                     beat_taken_o
);

	import cache_axi_pkg::*;

	sel_req_t            sel_d;
	sel_req_t            sel_q;
	logic [PORT_NUM-1:0] owner_q;
	logic                own_data_ok;
	logic [STRB_W-1:0]   own_strb;
	logic [DATA_W-1:0]   own_data;
	logic                buf_full_q;
	logic                buf_open;
	logic [STRB_W-1:0]   buf_strb_q;
	logic [DATA_W-1:0]   buf_data_q;

	// grant is one-hot
	always_comb begin
		sel_d = '0;
		for (int i = 0; i < PORT_NUM; i++) begin
			if (grant_i[i]) begin
				sel_d.write  = req_i[i].write;
				sel_d.burst  = req_i[i].burst;
				sel_d.cached = req_i[i].cached;
				sel_d.addr   = req_i[i].addr;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			owner_q <= '0;
		end else if (take_i && |grant_i) begin
			owner_q <= grant_i;
		end
	end

	always_ff @(posedge clk) begin
		if (take_i && |grant_i)
			sel_q <= sel_d;
	end

	// write beat of the owning port
	always_comb begin
		own_data_ok = 1'b0;
		own_strb    = '0;
		own_data    = '0;
		for (int i = 0; i < PORT_NUM; i++) begin
			if (owner_q[i]) begin
				own_data_ok = req_i[i].data_ok;
				own_strb    = req_i[i].strobe;
				own_data    = req_i[i].wdata;
			end
		end
	end

	assign buf_open     = !buf_full_q || w_ready_i; // empty or draining this cycle
	assign beat_taken_o = (state_i == ST_DATA) && sel_q.write && own_data_ok && buf_open;

	always_ff @(posedge clk) begin
		if (!rst_n) begin
			buf_full_q <= 1'b0;
		end else if (buf_open) begin
			buf_full_q <= beat_taken_o;
		end
	end

	always_ff @(posedge clk) begin
		if (beat_taken_o) begin
			buf_strb_q <= own_strb;
			buf_data_q <= own_data;
		end
	end

	always_comb begin
		w_o.valid = buf_full_q;
		w_o.data  = buf_data_q;
		w_o.strb  = buf_strb_q;
		w_o.last  = last_i;
	end

	assign sel_o      = sel_q;
	assign sel_port_o = owner_q;

endmodule

`default_nettype wire

// ==== hw/cache_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module cache_axi_bridge #(
	parameter int PORT_NUM  = 2,
	parameter int BURST_LEN = 4
) (
	input  logic                                      clk,
	input  logic                                      rst_n,
	input  cache_axi_pkg::cache_req_t  [PORT_NUM-1:0] req_i,
	output cache_axi_pkg::cache_resp_t [PORT_NUM-1:0] resp_o,
	output cache_axi_pkg::axi_addr_t                  ar_o,
	output cache_axi_pkg::axi_addr_t                  aw_o,
	output cache_axi_pkg::axi_w_t                     w_o,
	output logic                                      r_ready_o,
	output logic                                      b_ready_o,
	input  logic                                      ar_ready_i,
	input  logic                                      aw_ready_i,
	input  logic                                      w_ready_i,
	input  cache_axi_pkg::axi_r_t                     r_i,
	input  cache_axi_pkg::axi_b_t                     b_i
);

	import cache_axi_pkg::*;

	logic [PORT_NUM-1:0] req_valid;
	logic [PORT_NUM-1:0] grant;
	logic [PORT_NUM-1:0] sel_port;
	logic                take;
	logic                start;
	logic                grant_burst;
	logic                last_beat;
	logic                beat_taken;
	logic                w_fire;
	logic                rd_beat;
	bridge_state_e       state;
	sel_req_t            sel;
	axi_addr_t           addr_ch;

	rr_arbiter #(.PORT_NUM(PORT_NUM)) rr_arbiter_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.req_i   (req_valid),
		.take_i  (take),
		.grant_o (grant)
	);

	bridge_fsm bridge_fsm_inst (
		.clk         (clk),
		.rst_n       (rst_n),
		.grant_any_i (|grant),
		.write_i     (sel.write),
		.ar_ready_i  (ar_ready_i),
		.aw_ready_i  (aw_ready_i),
		.r_i         (r_i),
		.w_fire_i    (w_fire),
		.last_beat_i (last_beat),
		.b_valid_i   (b_i.valid),
		.state_o     (state),
		.take_o      (take),
		.start_o     (start)
	);

	// counter loads before the request is latched
	always_comb begin
		grant_burst = 1'b0;
		for (int i = 0; i < PORT_NUM; i++)
			grant_burst = grant_burst | (grant[i] & req_i[i].burst);
	end

	beat_counter #(.BURST_LEN(BURST_LEN)) beat_counter_inst (
		.clk     (clk),
		.rst_n   (rst_n),
		.start_i (start),
		.burst_i (grant_burst),
		.beat_i  (w_fire),
		.last_o  (last_beat)
	);

	req_capture #(.PORT_NUM(PORT_NUM)) req_capture_inst (
		.clk          (clk),
		.rst_n        (rst_n),
		.req_i        (req_i),
		.grant_i      (grant),
		.take_i       (take),
		.state_i      (state),
		.w_ready_i    (w_ready_i),
		.last_i       (last_beat),
		.sel_o        (sel),
		.sel_port_o   (sel_port),
		.w_o          (w_o),
		.beat_taken_o (beat_taken)
	);

	assign w_fire    = w_o.valid && w_ready_i;
	assign r_ready_o = (state == ST_DATA) && !sel.write;
	assign b_ready_o = (state == ST_RESP);
	assign rd_beat   = r_ready_o && r_i.valid;

	for (genvar i = 0; i < PORT_NUM; i++) begin : g_port
		assign req_valid[i]        = req_i[i].valid;
		assign resp_o[i].ready     = grant[i] & take;
		assign resp_o[i].data_ok   = sel_port[i] & (beat_taken | rd_beat);
		assign resp_o[i].data_last = sel_port[i] & rd_beat & r_i.last;
		assign resp_o[i].rdata     = r_i.data;
	end

	// AR and AW differ only in valid
	always_comb begin
		addr_ch       = '0;
		addr_ch.addr  = sel.addr;
		addr_ch.len   = sel.burst ? 8'(BURST_LEN - 1) : 8'd0;
		addr_ch.size  = 3'b010; // 4 bytes
		addr_ch.burst = sel.burst ? AXI_BURST_WRAP : AXI_BURST_INCR;
		addr_ch.cache = {2'b00, sel.cached, 1'b0}; // modifiable when cached
		addr_ch.prot  = 3'b001; // data, privileged
		ar_o          = addr_ch;
		ar_o.valid    = (state == ST_ADDR) && !sel.write;
		aw_o          = addr_ch;
		aw_o.valid    = (state == ST_ADDR) && sel.write;
	end

endmodule

`default_nettype wire

// ==== verif/tb_axi_mem.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_axi_mem (
	input  logic                     clk,
	input  logic                     rst_n,
	input  cache_axi_pkg::axi_addr_t ar_i,
	input  cache_axi_pkg::axi_addr_t aw_i,
	input  cache_axi_pkg::axi_w_t    w_i,
	input  logic                     r_ready_i,
	input  logic                     b_ready_i,
	output logic                     ar_ready_o,
	output logic                     aw_ready_o,
	output logic                     w_ready_o,
	output cache_axi_pkg::axi_r_t    r_o,
	output cache_axi_pkg::axi_b_t    b_o
);

	import cache_axi_pkg::*;

	logic [31:0] mem [logic [31:0]]; // word address keyed
	logic [31:0] lfsr;
	logic [31:0] rd_addr;
	logic [7:0]  rd_len;
	logic [7:0]  rd_left;
	logic        rd_wrap;
	logic        rd_busy;
	logic        r_took;
	logic [31:0] wr_addr;
	logic [7:0]  wr_len;
	logic        wr_wrap;
	logic        b_pend;
	logic        b_took;

	// galois lfsr, one step per bit
	function automatic logic lfsr_bit();
		lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h80200003) : (lfsr >> 1);
		return lfsr[0];
	endfunction

	function automatic logic [31:0] read_word(input logic [31:0] a);
		return mem.exists(a) ? mem[a] : (a ^ 32'h5a5a0000);
	endfunction

	function automatic logic [31:0] next_addr(input logic [31:0] a, input logic [7:0] len,
			input logic wrap);
		logic [31:0] span;
		span = ({24'd0, len} + 32'd1) << 2;
		if (!wrap)
			return a + 32'd4;
		return (a & ~(span - 32'd1)) | ((a + 32'd4) & (span - 32'd1));
	endfunction

	initial begin
		lfsr       = 32'hd1b;
		ar_ready_o = 1'b0;
		aw_ready_o = 1'b0;
		w_ready_o  = 1'b0;
		r_o        = '0;
		b_o        = '0;
		rd_busy    = 1'b0;
		b_pend     = 1'b0;
		r_took     = 1'b0;
		b_took     = 1'b0;
	end

	// handshakes seen at the rising edge
	always @(posedge clk) begin
		logic [31:0] word;
		if (!rst_n) begin
			rd_busy = 1'b0;
			b_pend  = 1'b0;
		end else begin
			if (ar_i.valid && ar_ready_o) begin
				rd_busy = 1'b1;
				rd_addr = ar_i.addr;
				rd_len  = ar_i.len;
				rd_left = ar_i.len;
				rd_wrap = (ar_i.burst == AXI_BURST_WRAP);
			end
			if (r_o.valid && r_ready_i) begin
				r_took = 1'b1;
				if (rd_left == 8'd0)
					rd_busy = 1'b0;
				rd_left = rd_left - 8'd1;
				rd_addr = next_addr(rd_addr, rd_len, rd_wrap);
			end
			if (aw_i.valid && aw_ready_o) begin
				wr_addr = aw_i.addr;
				wr_len  = aw_i.len;
				wr_wrap = (aw_i.burst == AXI_BURST_WRAP);
			end
			if (w_i.valid && w_ready_o) begin
				word = read_word(wr_addr);
				for (int i = 0; i < STRB_W; i++)
					if (w_i.strb[i])
						word[8*i +: 8] = w_i.data[8*i +: 8];
				mem[wr_addr] = word;
				wr_addr      = next_addr(wr_addr, wr_len, wr_wrap);
				if (w_i.last)
					b_pend = 1'b1;
			end
			if (b_o.valid && b_ready_i) begin
				b_took = 1'b1;
				b_pend = 1'b0;
			end
		end
	end

	// outputs change on the falling edge only
	always @(negedge clk) begin
		if (rst_n) begin
			ar_ready_o <= lfsr_bit();
			aw_ready_o <= lfsr_bit();
			w_ready_o  <= lfsr_bit(); // random W back-pressure
			if (!r_o.valid || r_took) begin
				if (rd_busy)
					r_o.valid <= lfsr_bit();
				else
					r_o.valid <= 1'b0;
				r_o.data <= read_word(rd_addr);
				r_o.last <= (rd_left == 8'd0);
				r_o.resp <= 2'b00;
			end
			if (!b_o.valid || b_took) begin
				if (b_pend)
					b_o.valid <= lfsr_bit();
				else
					b_o.valid <= 1'b0;
				b_o.resp <= 2'b00;
			end
			r_took = 1'b0;
			b_took = 1'b0;
		end
	end

endmodule

`default_nettype wire

// ==== verif/tb_cache_axi_bridge.sv ====
`timescale 1ns/1ps
`default_nettype none

module tb_cache_axi_bridge;

	import cache_axi_pkg::*;

	localparam int PORT_NUM    = 2;
	localparam int BURST_LEN   = 4;
	localparam int NUM_TXN     = 12;
	localparam int TIMEOUT_CYC = NUM_TXN * 64;

	typedef struct packed {
		logic        port;
		logic        write;
		logic        burst;
		logic        cached;
		logic [31:0] addr;
		logic [3:0]  strobe;
		logic [31:0] seed; // first write beat
	} txn_t;

	logic                       clk;
	logic                       rst_n;
	cache_req_t  [PORT_NUM-1:0] req;
	cache_resp_t [PORT_NUM-1:0] resp;
	cache_req_t                 drv [PORT_NUM];
	axi_addr_t                  ar;
	axi_addr_t                  aw;
	axi_w_t                     w;
	axi_r_t                     r;
	axi_b_t                     b;
	logic                       ar_ready;
	logic                       aw_ready;
	logic                       w_ready;
	logic                       r_ready;
	logic                       b_ready;
	txn_t                       txn_tab [NUM_TXN];
	logic [31:0]                shadow [logic [31:0]];
	int                         cur_idx [PORT_NUM];
	int                         act_idx = 0;
	int                         errors = 0;
	int                         w_cnt = 0;
	int                         w_expect = 0;
	int                         cycles = 0;
	logic                       last_gp = 1'b1; // so port 0 wins first
	logic                       ar_stall = 1'b0;
	logic                       aw_stall = 1'b0;
	axi_addr_t                  ar_prev;
	axi_addr_t                  aw_prev;

	for (genvar g = 0; g < PORT_NUM; g++) begin : g_drv
		assign req[g] = drv[g];
	end

	cache_axi_bridge #(.PORT_NUM(PORT_NUM), .BURST_LEN(BURST_LEN)) cache_axi_bridge_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.req_i      (req),
		.resp_o     (resp),
		.ar_o       (ar),
		.aw_o       (aw),
		.w_o        (w),
		.r_ready_o  (r_ready),
		.b_ready_o  (b_ready),
		.ar_ready_i (ar_ready),
		.aw_ready_i (aw_ready),
		.w_ready_i  (w_ready),
		.r_i        (r),
		.b_i        (b)
	);

	tb_axi_mem axi_mem_inst (
		.clk        (clk),
		.rst_n      (rst_n),
		.ar_i       (ar),
		.aw_i       (aw),
		.w_i        (w),
		.r_ready_i  (r_ready),
		.b_ready_i  (b_ready),
		.ar_ready_o (ar_ready),
		.aw_ready_o (aw_ready),
		.w_ready_o  (w_ready),
		.r_o        (r),
		.b_o        (b)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	task automatic set_txn(input int i, input logic port, input logic write, input logic burst,
			input logic cached, input logic [31:0] addr, input logic [3:0] strobe,
			input logic [31:0] seed);
		txn_tab[i] = {port, write, burst, cached, addr, strobe, seed};
	endtask

	function automatic logic [31:0] shadow_word(input logic [31:0] a);
		return shadow.exists(a) ? shadow[a] : (a ^ 32'h5a5a0000);
	endfunction

	task automatic shadow_write(input logic [31:0] a, input logic [31:0] d,
			input logic [3:0] s);
		logic [31:0] word;
		word = shadow_word(a);
		for (int i = 0; i < 4; i++)
			if (s[i])
				word[8*i +: 8] = d[8*i +: 8];
		shadow[a] = word;
	endtask

	// wrap order inside the aligned BURST_LEN*4 byte block
	function automatic logic [31:0] beat_addr(input logic [31:0] base, input int k,
			input logic burst);
		logic [31:0] blk;
		blk = 32'(BURST_LEN * 4);
		if (!burst)
			return base;
		return (base & ~(blk - 32'd1)) | ((base + 32'(4 * k)) & (blk - 32'd1));
	endfunction

	task automatic run_port(input logic p);
		txn_t        t;
		int          n;
		logic [31:0] a;
		logic [31:0] d;
		for (int i = 0; i < NUM_TXN; i++) begin
			t = txn_tab[i];
			if (t.port == p) begin
				@(negedge clk);
				cur_idx[p]     = i;
				drv[p].valid   = 1'b1;
				drv[p].write   = t.write;
				drv[p].burst   = t.burst;
				drv[p].cached  = t.cached;
				drv[p].addr    = t.addr;
				drv[p].data_ok = 1'b0;
				@(posedge clk);
				while (!resp[p].ready)
					@(posedge clk);
				@(negedge clk);
				drv[p].valid = 1'b0;
				n = t.burst ? BURST_LEN : 1;
				for (int k = 0; k < n; k++) begin
					a = beat_addr(t.addr, k, t.burst);
					if (t.write) begin
						d              = t.seed ^ (32'h01010101 * 32'(k));
						drv[p].data_ok = 1'b1;
						drv[p].strobe  = t.strobe;
						drv[p].wdata   = d;
						shadow_write(a, d, t.strobe);
					end
					@(posedge clk);
					while (!resp[p].data_ok)
						@(posedge clk);
					if (!t.write && resp[p].rdata != shadow_word(a)) begin
						errors++;
						$display("ERROR %0t: port %0d read %h at %h, expected %h", $time, p,
							resp[p].rdata, a, shadow_word(a));
					end
					if (!t.write && resp[p].data_last != (k == n - 1)) begin
						errors++;
						$display("ERROR %0t: port %0d data_last %0b on beat %0d of %0d", $time,
							p, resp[p].data_last, k, n);
					end
					if (t.write)
						@(negedge clk);
				end
				drv[p].data_ok = 1'b0;
			end
		end
	endtask

	task automatic check_addr(input axi_addr_t ch, input logic wr);
		txn_t t;
		t = txn_tab[act_idx];
		if (t.write != wr || ch.addr != t.addr ||
				ch.len != (t.burst ? 8'(BURST_LEN - 1) : 8'd0) ||
				ch.size != 3'd2 || ch.prot != 3'b001 ||
				ch.burst != (t.burst ? 2'b10 : 2'b01) || ch.cache[1] != t.cached) begin
			errors++;
			$display("ERROR %0t: %s addr %h len %0d size %0d burst %0d cache %h prot %0d %s %0d",
				$time, wr ? "AW" : "AR", ch.addr, ch.len, ch.size, ch.burst, ch.cache,
				ch.prot, "wrong for entry", act_idx);
		end
		w_cnt    = 0;
		w_expect = t.burst ? BURST_LEN : 1;
	endtask

	always @(posedge clk) begin
		logic gp;
		if (rst_n) begin
			if (resp[0].ready || resp[1].ready) begin
				gp = resp[1].ready;
				if (resp[0].ready && resp[1].ready) begin
					errors++;
					$display("ERROR %0t: both ports got a ready pulse", $time);
				end else if (req[0].valid && req[1].valid && gp == last_gp) begin
					errors++;
					$display("ERROR %0t: port %0d granted twice in a row", $time, gp);
				end
				last_gp = gp;
				act_idx = cur_idx[gp];
			end
			if (resp[!last_gp].data_ok || resp[!last_gp].data_last) begin
				errors++;
				$display("ERROR %0t: response on port %0d while port %0d owns the bus", $time,
					!last_gp, last_gp);
			end
			if (ar.valid && ar_ready)
				check_addr(ar, 1'b0);
			if (aw.valid && aw_ready)
				check_addr(aw, 1'b1);
			if ((ar_stall && ar != ar_prev) || (aw_stall && aw != aw_prev)) begin
				errors++;
				$display("ERROR %0t: address channel changed while stalled", $time);
			end
			ar_stall = ar.valid && !ar_ready;
			aw_stall = aw.valid && !aw_ready;
			ar_prev  = ar;
			aw_prev  = aw;
			if ((ar.valid || aw.valid) && (resp[0].data_ok || resp[1].data_ok)) begin
				errors++;
				$display("ERROR %0t: data_ok during address phase", $time);
			end
			if (((r_ready || b_ready) && (ar.valid || aw.valid || w.valid)) ||
					(r_ready && b_ready)) begin
				errors++;
				$display("ERROR %0t: r_ready %0b b_ready %0b outside their phase", $time,
					r_ready, b_ready);
			end
			if (w.valid && w_ready) begin
				w_cnt++;
				if (w.last != (w_cnt == w_expect)) begin
					errors++;
					$display("ERROR %0t: W last %0b on beat %0d of %0d", $time, w.last,
						w_cnt, w_expect);
				end
			end
		end
	end

	initial begin
		while (cycles < TIMEOUT_CYC) begin
			@(posedge clk);
			cycles++;
		end
		$display("timeout: transactions still pending after %0d cycles", cycles);
		$display("%0d transactions, %0d errors", NUM_TXN, errors);
		$display("TEST FAIL");
		$finish;
	end

	initial begin
		rst_n = 1'b0;
		for (int i = 0; i < PORT_NUM; i++) begin
			drv[i]     = '0;
			cur_idx[i] = 0;
		end
		// port, write, burst, cached, addr, strobe, seed
		set_txn(0,  1'b0, 1'b0, 1'b0, 1'b1, 32'h1004, 4'h0, 32'h0);
		set_txn(1,  1'b1, 1'b1, 1'b1, 1'b1, 32'h200c, 4'hf, 32'hcafe0000);
		set_txn(2,  1'b0, 1'b0, 1'b1, 1'b1, 32'h1008, 4'h0, 32'h0);
		set_txn(3,  1'b1, 1'b0, 1'b1, 1'b0, 32'h2004, 4'h0, 32'h0);
		set_txn(4,  1'b0, 1'b1, 1'b0, 1'b0, 32'h1010, 4'h6, 32'h12345678);
		set_txn(5,  1'b1, 1'b0, 1'b0, 1'b0, 32'h2100, 4'h0, 32'h0);
		set_txn(6,  1'b0, 1'b0, 1'b0, 1'b1, 32'h1010, 4'h0, 32'h0);
		set_txn(7,  1'b1, 1'b1, 1'b0, 1'b1, 32'h2104, 4'h8, 32'h89abcdef);
		set_txn(8,  1'b0, 1'b1, 1'b1, 1'b1, 32'h1024, 4'hb, 32'h0badf00d);
		set_txn(9,  1'b1, 1'b0, 1'b0, 1'b1, 32'h2104, 4'h0, 32'h0);
		set_txn(10, 1'b0, 1'b0, 1'b1, 1'b0, 32'h1028, 4'h0, 32'h0);
		set_txn(11, 1'b1, 1'b0, 1'b1, 1'b1, 32'h210c, 4'h0, 32'h0);
		repeat (16) @(negedge clk);
		rst_n = 1'b1;
		fork
			run_port(1'b0);
			run_port(1'b1);
		join
		repeat (8) @(negedge clk);
		$display("%0d transactions, %0d errors", NUM_TXN, errors);
		if (errors == 0)
			$display("TEST PASS");
		else
			$display("TEST FAIL");
		$finish;
	end

endmodule

`default_nettype wire

// ==== project.f ====
hw/cache_axi_pkg.sv
hw/rr_arbiter.sv
hw/beat_counter.sv
hw/bridge_fsm.sv
hw/req_capture.sv
hw/cache_axi_bridge.sv
verif/tb_axi_mem.sv
verif/tb_cache_axi_bridge.sv

// ==== run.sh ====
#!/bin/sh
# compile and run the bridge testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log
TOP=tb_cache_axi_bridge

verilator --binary --timing -Wno-fatal --timescale 1ns/1ps \
	-f project.f --top-module "$TOP" -o "$TOP"
status=$?
if [ "$status" -ne 0 ]; then
	echo "verilator build failed with status $status"
	exit 1
fi

./obj_dir/"$TOP" > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit 1
fi

if grep -q "TEST FAIL" "$LOG"; then
	echo "simulation reported failure, see $LOG"
	exit 1
fi

exit 0
